// File: vlog.f
+incdir+include
hw/mac_pkg.sv
hw/mac_operand_decode.sv
hw/mac_accumulate.sv
hw/mac_result_select.sv
hw/mac_32bit.sv
verification/mac_tb.sv

// File: include/mac_model.svh
// mac reference model
// tracks the accumulator and select register and predicts mac_out

`ifndef MAC_MODEL_SVH
`define MAC_MODEL_SVH

mac_pkg::acc_t     model_acc;
mac_pkg::out_sel_t model_sel;

// full product of two operands sign or zero extended to 80 bits
function automatic mac_pkg::acc_t model_product(
  input mac_pkg::operand_t a,
  input mac_pkg::operand_t b,
  input logic              tc
);
  logic signed [2*mac_pkg::OPERAND_W-1:0] sp;
  logic        [2*mac_pkg::OPERAND_W-1:0] up;
  if (tc) begin
    sp = $signed(a) * $signed(b);
    model_product = mac_pkg::acc_t'(sp);
  end else begin
    up = a * b;
    model_product = mac_pkg::acc_t'(up);
  end
endfunction

// one bit set at s-1 for selects 1 to 48
function automatic mac_pkg::acc_t model_bias(input mac_pkg::out_sel_t sel);
  model_bias = '0;
  if ((sel >= 1) && (sel <= 48)) begin
    model_bias[sel-1] = 1'b1;
  end
endfunction

task automatic model_reset();
  model_acc = '0;
  model_sel = '0;
endtask

// applies one rising edge with the inputs sampled there
task automatic model_clock(
  input logic              clk_en,
  input mac_pkg::operand_t oper,
  input mac_pkg::operand_t coef,
  input logic              rnd,
  input logic              clear,
  input mac_pkg::out_sel_t sel,
  input logic              tc
);
  mac_pkg::acc_t addend;
  if (clear) begin
    addend = '0;
  end else if (rnd) begin
    addend = model_bias(sel);
  end else begin
    addend = model_acc;
  end
  if (clk_en) begin
    model_acc = model_product(oper, coef, tc) + addend;
  end
  model_sel = sel;
endtask

// expected output from the model state and the live saturation and mode
function automatic mac_pkg::operand_t model_out(input logic sat, input logic tc);
  int   s;
  logic all_one;
  logic all_zero;
  logic uns_zero;
  s = (model_sel > 48) ? 0 : int'(model_sel);
  model_out = model_acc[s +: 32];
  all_one  = 1'b1;
  all_zero = 1'b1;
  uns_zero = 1'b1;
  for (int i = s + 31; i < mac_pkg::ACC_W; i++) begin
    all_one  = all_one & model_acc[i];
    all_zero = all_zero & !model_acc[i];
    if (i > s + 31) begin
      uns_zero = uns_zero & !model_acc[i];
    end
  end
  if (sat && !(all_one || all_zero || (!tc && uns_zero))) begin
    if (!tc) begin
      model_out = 32'hffff_ffff;
    end else if (model_acc[mac_pkg::ACC_W-1]) begin
      model_out = 32'h8000_0000;
    end else begin
      model_out = 32'h7fff_ffff;
    end
  end
endfunction

`endif

// File: verification/mac_tb.sv
// mac testbench
// random stimulus on the falling edge, checked against the reference model

`timescale 1ns/1ps

module mac_tb;

  // about 1900 cycles of tests plus margin
  localparam int CYCLE_LIMIT = 3000;

  logic              MAC_ACC_CLK;
  logic              acc_ff_rstn;
  logic              clk_en;
  mac_pkg::operand_t oper_data;
  mac_pkg::operand_t coef_data;
  logic              acc_rnd;
  logic              acc_clear;
  logic              acc_sat;
  mac_pkg::out_sel_t out_sel;
  logic              tc;
  mac_pkg::operand_t mac_out;

  int cycle_count;
  int check_count;
  int error_count;

  `include "mac_model.svh"

  mac_32bit mac_32bit_i (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .clk_en      (clk_en),
    .oper_data   (oper_data),
    .coef_data   (coef_data),
    .acc_rnd     (acc_rnd),
    .acc_clear   (acc_clear),
    .acc_sat     (acc_sat),
    .out_sel     (out_sel),
    .tc          (tc),
    .mac_out     (mac_out)
  );

  // 8 ns period
  always #4 MAC_ACC_CLK = ~MAC_ACC_CLK;

  // the run is cut off if the tests take far longer than expected
  always @(posedge MAC_ACC_CLK) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run stopped at the cycle limit of %0d before the tests finished", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic rand_bit();
    rand_bit = ($urandom_range(1, 0) == 1);
  endfunction

  function automatic mac_pkg::out_sel_t rand_sel(input int hi);
    rand_sel = mac_pkg::out_sel_t'($urandom_range(hi, 0));
  endfunction

  // the bits under the msb are forced opposite to it
  // so the value is large whether it is read as signed or unsigned
  function automatic mac_pkg::operand_t big_operand();
    mac_pkg::operand_t value;
    value = $urandom;
    value[30:27] = {4{~value[31]}};
    big_operand = value;
  endfunction

  // mac_out against the model under the live saturation and mode
  task automatic check_out();
    mac_pkg::operand_t expected;
    expected = model_out(acc_sat, tc);
    check_count++;
    if (mac_out !== expected) begin
      error_count++;
      $display("Fail at %0t ns: mac_out expected %h got %h", $time, expected, mac_out);
    end
  endtask

  // drives one set of inputs on the falling edge
  // the check before the rising edge still sees the old select and accumulator
  // and the check after it sees the values loaded on that edge
  task automatic run_cycle(
    input logic              en,
    input mac_pkg::operand_t oper,
    input mac_pkg::operand_t coef,
    input logic              rnd,
    input logic              clear,
    input logic              sat,
    input mac_pkg::out_sel_t sel,
    input logic              mode
  );
    @(negedge MAC_ACC_CLK);
    clk_en    = en;
    oper_data = oper;
    coef_data = coef;
    acc_rnd   = rnd;
    acc_clear = clear;
    acc_sat   = sat;
    out_sel   = sel;
    tc        = mode;
    #1;
    check_out();
    @(posedge MAC_ACC_CLK);
    model_clock(clk_en, oper_data, coef_data, acc_rnd, acc_clear, out_sel, tc);
    #2;
    check_out();
  endtask

  initial begin
    logic              mode;
    logic              sat;
    mac_pkg::out_sel_t sel;
    mac_pkg::operand_t held_out;
    void'($urandom(99942));
    MAC_ACC_CLK = 1'b0;
    acc_ff_rstn = 1'b0;
    clk_en      = 1'b0;
    oper_data   = '0;
    coef_data   = '0;
    acc_rnd     = 1'b0;
    acc_clear   = 1'b0;
    acc_sat     = 1'b0;
    out_sel     = '0;
    tc          = 1'b0;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    model_reset();
    repeat (3) @(posedge MAC_ACC_CLK);
    @(negedge MAC_ACC_CLK);
    acc_ff_rstn = 1'b1;

    // idle after reset with nothing accumulated yet
    repeat (4) begin
      run_cycle(1'b0, $urandom, $urandom, 1'b0, 1'b0, rand_bit(), rand_sel(63), rand_bit());
      check_count++;
      if (mac_out !== '0) begin
        error_count++;
        $display("Fail at %0t ns: mac_out expected %h got %h", $time, 32'h0, mac_out);
      end
    end

    // unsigned then signed runs that each open with a clear
    for (int m = 0; m < 2; m++) begin
      mode = (m == 1);
      for (int run = 0; run < 20; run++) begin
        for (int k = 0; k < 25; k++) begin
          run_cycle(1'b1, $urandom, $urandom, 1'b0, (k == 0), 1'b0, rand_sel(63), mode);
        end
      end
    end

    // enable low with the output controls first held and then moving
    for (int run = 0; run < 10; run++) begin
      mode = rand_bit();
      sat  = rand_bit();
      sel  = rand_sel(48);
      run_cycle(1'b1, big_operand(), big_operand(), 1'b0, 1'b1, sat, sel, mode);
      run_cycle(1'b1, $urandom, $urandom, 1'b0, 1'b0, sat, sel, mode);
      held_out = mac_out;
      repeat (10) begin
        run_cycle(1'b0, $urandom, $urandom, rand_bit(), rand_bit(), sat, sel, mode);
        check_count++;
        if (mac_out !== held_out) begin
          error_count++;
          $display("Fail at %0t ns: mac_out expected %h got %h", $time, held_out, mac_out);
        end
      end
      repeat (8) begin
        run_cycle(1'b0, $urandom, $urandom, rand_bit(), rand_bit(), rand_bit(), rand_sel(63),
                  rand_bit());
      end
    end

    // large products pile up until the window overflows
    for (int run = 0; run < 40; run++) begin
      mode = rand_bit();
      for (int k = 0; k < 10; k++) begin
        run_cycle(1'b1, big_operand(), big_operand(), 1'b0, (k == 0), 1'b1, rand_sel(63), mode);
      end
    end

    // every edge restarts from the product plus the bias of its own select
    for (int run = 0; run < 40; run++) begin
      mode = rand_bit();
      for (int k = 0; k < 5; k++) begin
        run_cycle(1'b1, $urandom, $urandom, 1'b1, 1'b0, rand_bit(), rand_sel(63), mode);
      end
    end

    // select sweep over a fixed accumulator where the window follows one edge late
    for (int run = 0; run < 5; run++) begin
      mode = rand_bit();
      run_cycle(1'b1, big_operand(), big_operand(), 1'b0, 1'b1, 1'b0, '0, mode);
      for (int k = 0; k < 20; k++) begin
        run_cycle(1'b0, $urandom, $urandom, 1'b0, 1'b0, 1'b0, rand_sel(63), mode);
      end
    end

    $display("checks run %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: hw/mac_32bit.sv
// mac 32-bit top level
// connects operand decode, the accumulate stage and the result select

`timescale 1ns/1ps

module mac_32bit (
  input  logic              MAC_ACC_CLK,
  input  logic              acc_ff_rstn,
  input  logic              clk_en,
  input  mac_pkg::operand_t oper_data,
  input  mac_pkg::operand_t coef_data,
  input  logic              acc_rnd,
  input  logic              acc_clear,
  input  logic              acc_sat,
  input  mac_pkg::out_sel_t out_sel,
  input  logic              tc,
  output mac_pkg::operand_t mac_out
);

  // extended operands from decode to the multiplier
  mac_pkg::ext_operand_t oper_ext;
  mac_pkg::ext_operand_t coef_ext;

  // rounding bias built from the live select
  mac_pkg::acc_t rnd_bias;

  // registered accumulator feeding the output window
  mac_pkg::acc_t acc;

  // decode is purely combinational
  mac_operand_decode mac_operand_decode_i (
    .oper_data (oper_data),
    .coef_data (coef_data),
    .tc        (tc),
    .out_sel   (out_sel),
    .oper_ext  (oper_ext),
    .coef_ext  (coef_ext),
    .rnd_bias  (rnd_bias)
  );

  // one cycle from an enabled edge to the new accumulator value
  mac_accumulate mac_accumulate_i (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .clk_en      (clk_en),
    .oper_ext    (oper_ext),
    .coef_ext    (coef_ext),
    .tc          (tc),
    .rnd_bias    (rnd_bias),
    .acc_clear   (acc_clear),
    .acc_rnd     (acc_rnd),
    .acc         (acc)
  );

  // combinational from acc, with the select delayed by one register
  mac_result_select mac_result_select_i (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .out_sel     (out_sel),
    .acc         (acc),
    .acc_sat     (acc_sat),
    .tc          (tc),
    .mac_out     (mac_out)
  );

endmodule

// File: hw/mac_result_select.sv
// mac result select
// registers the shift select, extracts the 32-bit output window and saturates it

`timescale 1ns/1ps

module mac_result_select (
  input  logic              MAC_ACC_CLK,
  input  logic              acc_ff_rstn,
  input  mac_pkg::out_sel_t out_sel,
  input  mac_pkg::acc_t     acc,
  input  logic              acc_sat,
  input  logic              tc,
  output mac_pkg::operand_t mac_out
);

  mac_pkg::out_sel_t sel_q;
  mac_pkg::out_sel_t sel_eff;
  mac_pkg::acc_t     acc_shift;
  mac_pkg::operand_t window;
  mac_pkg::acc_t     sign_mask;
  mac_pkg::acc_t     uns_mask;
  logic              hi_ones;
  logic              hi_zero;
  logic              uns_zero;
  logic              no_ovf;
  mac_pkg::operand_t clamp;

  // the select follows the port on every edge
  // it does not wait for the clock enable so the window lines up
  // with the accumulator value written on the same edge
  always_ff @(posedge MAC_ACC_CLK or negedge acc_ff_rstn) begin
    if (!acc_ff_rstn) begin
      sel_q <= '0;
    end else begin
      sel_q <= out_sel;
    end
  end

  // selects past the limit would run off the top of the accumulator
  // they behave as select 0
  assign sel_eff = (sel_q > mac_pkg::MAX_SHIFT) ? '0 : sel_q;

  // the window is acc bits s+31 down to s
  assign acc_shift = acc >> sel_eff;
  assign window    = acc_shift[mac_pkg::OPERAND_W-1:0];

  // sign_mask covers bits s+31 up to the accumulator msb
  // these must all agree for the window to hold the signed value exactly
  assign sign_mask = ({mac_pkg::ACC_W{1'b1}} << sel_eff) << (mac_pkg::OPERAND_W - 1);

  // uns_mask covers the bits above the window, s+32 and up
  // at the top select it shifts out completely and the test passes trivially
  assign uns_mask = sign_mask << 1;

  assign hi_ones  = ((acc & sign_mask) == sign_mask);
  assign hi_zero  = ((acc & sign_mask) == '0);
  assign uns_zero = ((acc & uns_mask) == '0);

  // an unsigned result also fits when only the bits above the window are zero
  // because then the window msb is a plain magnitude bit
  // the rule is the same for every select from 0 to the limit
  assign no_ovf = hi_ones | hi_zero | (!tc & uns_zero);

  // clamp values on overflow
  // unsigned overflow pins the output to all ones
  // signed overflow goes to the most negative or most positive word
  // and the accumulator msb tells which side the true value lies on
  always_comb begin
    if (!tc) begin
      clamp = '1;
    end else if (acc[mac_pkg::ACC_W-1]) begin
      clamp = {1'b1, {(mac_pkg::OPERAND_W-1){1'b0}}};
    end else begin
      clamp = {1'b0, {(mac_pkg::OPERAND_W-1){1'b1}}};
    end
  end

  // saturation and mode act on the output in the same cycle
  // with saturation off the raw window goes out even when it wraps
  assign mac_out = (acc_sat && !no_ovf) ? clamp : window;

endmodule

// File: hw/mac_accumulate.sv
// mac accumulate stage
// picks the addend, forms the 80-bit multiply-add and holds the accumulator

`timescale 1ns/1ps

module mac_accumulate (
  input  logic                  MAC_ACC_CLK,
  input  logic                  acc_ff_rstn,
  input  logic                  clk_en,
  input  mac_pkg::ext_operand_t oper_ext,
  input  mac_pkg::ext_operand_t coef_ext,
  input  logic                  tc,
  input  mac_pkg::acc_t         rnd_bias,
  input  logic                  acc_clear,
  input  logic                  acc_rnd,
  output mac_pkg::acc_t         acc
);

  mac_pkg::acc_t oper_wide;
  mac_pkg::acc_t coef_wide;
  mac_pkg::acc_t product;
  mac_pkg::acc_t addend;
  mac_pkg::acc_t acc_nxt;

  // the extended operands are widened again to the accumulator width
  // so that a plain multiply truncated to 80 bits gives the right product
  // signed mode repeats bit 39 and unsigned mode fills with zeros
  always_comb begin
    if (tc) begin
      oper_wide = {{mac_pkg::EXT_W{oper_ext[mac_pkg::EXT_W-1]}}, oper_ext};
      coef_wide = {{mac_pkg::EXT_W{coef_ext[mac_pkg::EXT_W-1]}}, coef_ext};
    end else begin
      oper_wide = {{mac_pkg::EXT_W{1'b0}}, oper_ext};
      coef_wide = {{mac_pkg::EXT_W{1'b0}}, coef_ext};
    end
  end

  // product modulo 2 to the power 80
  assign product = oper_wide * coef_wide;

  // clear wins over round and round wins over the running sum
  // clear starts a new sum from the product alone
  // round starts a new sum from the product plus the rounding bias
  always_comb begin
    if (acc_clear) begin
      addend = '0;
    end else if (acc_rnd) begin
      addend = rnd_bias;
    end else begin
      addend = acc;
    end
  end

  // the adder wraps at 80 bits just like the product
  assign acc_nxt = product + addend;

  // the accumulator only moves on an enabled edge
  // with the enable low it keeps its value whatever the operands do
  always_ff @(posedge MAC_ACC_CLK or negedge acc_ff_rstn) begin
    if (!acc_ff_rstn) begin
      acc <= '0;
    end else if (clk_en) begin
      acc <= acc_nxt;
    end
  end

endmodule

// File: hw/mac_operand_decode.sv
// mac operand decode
// extends both operands by number mode and builds the rounding bias

`timescale 1ns/1ps

module mac_operand_decode (
  input  mac_pkg::operand_t     oper_data,
  input  mac_pkg::operand_t     coef_data,
  input  logic                  tc,
  input  mac_pkg::out_sel_t     out_sel,
  output mac_pkg::ext_operand_t oper_ext,
  output mac_pkg::ext_operand_t coef_ext,
  output mac_pkg::acc_t         rnd_bias
);

  // copies the operand msb into the pad bits in signed mode
  // in unsigned mode the pad bits stay zero
  function automatic mac_pkg::ext_operand_t pad_operand(
    input mac_pkg::operand_t data,
    input logic              is_signed
  );
    logic pad_bit;
    pad_bit = is_signed & data[mac_pkg::OPERAND_W-1];
    pad_operand = {{mac_pkg::PAD_W{pad_bit}}, data};
  endfunction

  // both operands share the same mode bit
  assign oper_ext = pad_operand(oper_data, tc);
  assign coef_ext = pad_operand(coef_data, tc);

  // the bias is half a unit of the selected output lsb
  // so a window at bit s gets 2 to the power s-1 added before truncation
  // select 0 has nothing below it to round and gets no bias
  // selects above the limit map to the bit-0 window and also get none
  // the live select is used here since the bias enters the adder this cycle
  always_comb begin
    rnd_bias = '0;
    if ((out_sel != '0) && (out_sel <= mac_pkg::MAX_SHIFT)) begin
      rnd_bias = mac_pkg::acc_t'(1) << (out_sel - mac_pkg::out_sel_t'(1));
    end
  end

endmodule

// File: hw/mac_pkg.sv
// mac package
// widths, vector types and limits shared by the 32-bit multiply-accumulate unit

package mac_pkg;

  // width of an input operand and of the output window
  localparam int OPERAND_W = 32;

  // extra bits placed above each operand before the multiply
  localparam int PAD_W = 8;

  // an extended operand is the operand plus its pad bits
  localparam int EXT_W = OPERAND_W + PAD_W;

  // the accumulator holds the full product of two extended operands
  localparam int ACC_W = 2 * EXT_W;

  // the shift select picks the lsb of the output window
  localparam int SEL_W = 6;

  // operand or output word
  typedef logic [OPERAND_W-1:0] operand_t;

  // operand after sign or zero extension
  typedef logic [EXT_W-1:0] ext_operand_t;

  // accumulator value and the addend fed back into the adder
  typedef logic [ACC_W-1:0] acc_t;

  // shift select as it arrives on the port
  typedef logic [SEL_W-1:0] out_sel_t;

  // largest select that still fits a full window inside the accumulator
  // selects above this fall back to the window at bit 0
  localparam out_sel_t MAX_SHIFT = out_sel_t'(48);

endpackage
